/* dv/tb_score_display.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_score_display;

    localparam int MAX_SCORE      = 20; // short games so that the limit is reached often.
    localparam int RESET_CYCLES   = 10;
    localparam int NUM_OPS        = 300;
    localparam int GAP_CYCLES     = 8;
    localparam int OP_CYCLES      = 16; // one edge, the longest hold and the gap.
    localparam int TIMEOUT_CYCLES = NUM_OPS * OP_CYCLES + RESET_CYCLES + 100;
    localparam int BLANK          = 127;

    typedef enum {OP_GOOD, OP_BAD, OP_BOTH} op_e;

    logic       clk;
    logic       nRst;
    logic       good_coll;
    logic       bad_coll;
    logic [7:0] current_score;
    logic [7:0] disp_score;
    logic [3:0] bcd_ones;
    logic [3:0] bcd_tens;
    logic [3:0] bcd_hundreds;
    logic [6:0] seg_ones;
    logic [6:0] seg_tens;
    logic [6:0] seg_hundreds;
    logic       game_over;
    logic       high_led;

    logic [15:0] lfsr_state;
    int          model_score;
    int          model_high;
    logic        model_over;
    int          mismatch_count;
    int          failure_count;
    int          cycle_count;
    bit          seen_disp [0:255];

    score_display_top #(
        .MAX_SCORE (MAX_SCORE)
    ) u_score_display_top (
        .clk           (clk),
        .nRst          (nRst),
        .good_coll     (good_coll),
        .bad_coll      (bad_coll),
        .current_score (current_score),
        .disp_score    (disp_score),
        .bcd_ones      (bcd_ones),
        .bcd_tens      (bcd_tens),
        .bcd_hundreds  (bcd_hundreds),
        .seg_ones      (seg_ones),
        .seg_tens      (seg_tens),
        .seg_hundreds  (seg_hundreds),
        .game_over     (game_over),
        .high_led      (high_led)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // taps at 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    // builds the active low pattern from the segments that are lit for a digit.
    function automatic int seg_expect(input int digit);
        string      lit;
        logic [6:0] pattern;
        int         seg_idx;
        case (digit)
            0:       lit = "abcdef";
            1:       lit = "bc";
            2:       lit = "abdeg";
            3:       lit = "abcdg";
            4:       lit = "bcfg";
            5:       lit = "acdfg";
            6:       lit = "acdefg";
            7:       lit = "abc";
            8:       lit = "abcdefg";
            9:       lit = "abcdfg";
            default: lit = "";
        endcase
        pattern = 7'h7f;
        for (int i = 0; i < lit.len(); i++) begin
            seg_idx = int'(lit[i]) - int'("a");
            pattern = pattern & ~(7'b1 << seg_idx);
        end
        return int'(pattern);
    endfunction

    task automatic check_value(input string what, input int got, input int expected);
        if (got != expected) begin
            mismatch_count++;
            $display("MISMATCH at time %0d ns: %s is %0d, expected %0d",
                     $time, what, got, expected);
        end
    endtask

    task automatic apply_model(input op_e op);
        int   final_score;
        logic end_now;
        final_score = model_score;
        end_now     = 1'b0;
        if (op == OP_GOOD) begin
            final_score = model_over ? 1 : model_score + 1; // a press after game over starts anew.
            model_over  = 1'b0;
            model_score = final_score;
            end_now     = (final_score == MAX_SCORE);
        end else begin
            end_now = !model_over; // a bad hit while over is ignored.
        end
        if (end_now) begin
            if (final_score > model_high) begin
                model_high = final_score;
            end
            model_score = 0;
            model_over  = 1'b1;
        end
    endtask

    task automatic press(input op_e op, input int hold);
        @(posedge clk);
        good_coll <= (op != OP_BAD);
        bad_coll  <= (op != OP_GOOD);
        repeat (hold) @(posedge clk);
        good_coll <= 1'b0;
        bad_coll  <= 1'b0;
        repeat (GAP_CYCLES) @(posedge clk);
    endtask

    task automatic check_outputs(input string tag);
        int disp;
        int hundreds;
        int tens;
        int ones;
        disp     = model_over ? model_high : model_score;
        hundreds = disp / 100;
        tens     = (disp / 10) % 10;
        ones     = disp % 10;
        check_value({tag, " current_score"}, int'(current_score), model_score);
        check_value({tag, " disp_score"}, int'(disp_score), disp);
        check_value({tag, " game_over"}, int'(game_over), int'(model_over));
        check_value({tag, " high_led"}, int'(high_led), int'(model_over));
        check_value({tag, " bcd_hundreds"}, int'(bcd_hundreds), hundreds);
        check_value({tag, " bcd_tens"}, int'(bcd_tens), tens);
        check_value({tag, " bcd_ones"}, int'(bcd_ones), ones);
        check_value({tag, " seg_hundreds"}, int'(seg_hundreds),
                    (hundreds == 0) ? BLANK : seg_expect(hundreds));
        check_value({tag, " seg_tens"}, int'(seg_tens),
                    (hundreds == 0 && tens == 0) ? BLANK : seg_expect(tens));
        check_value({tag, " seg_ones"}, int'(seg_ones), seg_expect(ones));
        seen_disp[disp_score] = 1'b1;
    endtask

    initial begin
        op_e op;
        int  pick;
        int  hold_bits;
        int  required [5];
        nRst           <= 1'b0;
        good_coll      <= 1'b0;
        bad_coll       <= 1'b0;
        lfsr_state     = 16'd10;
        model_score    = 0;
        model_high     = 0;
        model_over     = 1'b0;
        mismatch_count = 0;
        failure_count  = 0;
        required       = '{0, 9, 10, 19, 20};

        repeat (RESET_CYCLES) @(posedge clk);
        nRst <= 1'b1;
        @(negedge clk);
        check_outputs("after reset");

        for (int i = 0; i < NUM_OPS; i++) begin
            // the first game runs up to the limit, then a bad hit while over and a restart.
            if (i < MAX_SCORE) begin
                op = OP_GOOD;
            end else if (i == MAX_SCORE) begin
                op = OP_BAD;
            end else if (i == MAX_SCORE + 1) begin
                op = OP_GOOD;
            end else begin
                take_bits(7, pick);
                if (pick < 109) begin
                    op = OP_GOOD;
                end else if (pick < 119) begin
                    op = OP_BAD;
                end else begin
                    op = OP_BOTH;
                end
            end
            take_bits(2, hold_bits);
            press(op, 4 + hold_bits);
            apply_model(op);
            @(negedge clk);
            check_outputs($sformatf("op %0d (%s)", i, op.name()));
        end

        for (int k = 0; k < 5; k++) begin
            if (!seen_disp[required[k]]) begin
                failure_count++;
                $display("ERROR: displayed score %0d never appeared during the run", required[k]);
            end
        end

        $display("errors: %0d value mismatches, %0d other failures",
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: the run hung and did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/bcd_converter.sv */
`timescale 1ns/100ps
`default_nettype none

module bcd_converter (
    input  logic             clk,
    input  logic             nRst,
    input  game_pkg::score_t disp_score,
    input  logic             show_high,
    digit_if.source          digits
);

    localparam int BCD_W  = 12;
    localparam int WORK_W = BCD_W + game_pkg::SCORE_W;

    logic [WORK_W-1:0] work;

    // shift and add three, one pass per score bit.
    always_comb begin
        work = {{BCD_W{1'b0}}, disp_score};
        for (int i = 0; i < game_pkg::SCORE_W; i++) begin
            for (int d = 0; d < BCD_W / 4; d++) begin
                if (work[game_pkg::SCORE_W + 4*d +: 4] >= 4'd5) begin
                    work[game_pkg::SCORE_W + 4*d +: 4] =
                        work[game_pkg::SCORE_W + 4*d +: 4] + 4'd3;
                end
            end
            work = work << 1;
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            digits.ones      <= '0;
            digits.tens      <= '0;
            digits.hundreds  <= '0;
            digits.show_high <= 1'b0;
        end else begin
            digits.ones      <= work[game_pkg::SCORE_W +: 4];
            digits.tens      <= work[game_pkg::SCORE_W + 4 +: 4];
            digits.hundreds  <= work[game_pkg::SCORE_W + 8 +: 4];
            digits.show_high <= show_high; // keeps the flag in step with the digits.
        end
    end

endmodule

`default_nettype wire

/* rtl/collision_detect.sv */
`timescale 1ns/100ps
`default_nettype none

module collision_detect (
    input  logic             clk,
    input  logic             nRst,
    input  logic             good_coll,
    input  logic             bad_coll,
    output game_pkg::event_e ev
);

    logic [1:0] good_sync;
    logic [1:0] bad_sync;
    logic       good_last;
    logic       bad_last;
    logic       good_rise;
    logic       bad_rise;

    assign good_rise = good_sync[1] & ~good_last;
    assign bad_rise  = bad_sync[1] & ~bad_last;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            good_sync <= 2'b00;
            bad_sync  <= 2'b00;
            good_last <= 1'b0;
            bad_last  <= 1'b0;
            ev        <= game_pkg::EV_NONE;
        end else begin
            good_sync <= {good_sync[0], good_coll};
            bad_sync  <= {bad_sync[0], bad_coll};
            good_last <= good_sync[1];
            bad_last  <= bad_sync[1];
            if (bad_rise) begin
                ev <= game_pkg::EV_BAD; // a bad hit wins over a good one.
            end else if (good_rise) begin
                ev <= game_pkg::EV_GOOD;
            end else begin
                ev <= game_pkg::EV_NONE;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/digit_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface digit_if;

    display_pkg::bcd_t ones;
    display_pkg::bcd_t tens;
    display_pkg::bcd_t hundreds;
    logic              show_high; // digits hold the high score.

    modport source (
        output ones, tens, hundreds, show_high
    );

    modport sink (
        input ones, tens, hundreds, show_high
    );

endinterface

`default_nettype wire

/* rtl/display_pkg.sv */
`default_nettype none

package display_pkg;

    typedef logic [3:0] bcd_t;

    // active low segments, bit 0 is segment a and bit 6 is segment g.
    typedef logic [6:0] seg_t;

    localparam seg_t SEG_BLANK = 7'b111_1111;

endpackage

`default_nettype wire

/* rtl/game_pkg.sv */
`default_nettype none

package game_pkg;

    localparam int SCORE_W = 8; // three decimal digits cover the full range.

    typedef logic [SCORE_W-1:0] score_t;

    // collision seen in one cycle after edge detection.
    typedef enum logic [1:0] {
        EV_NONE = 2'd0,
        EV_GOOD = 2'd1,
        EV_BAD  = 2'd2
    } event_e;

    typedef enum logic {
        PLAYING = 1'b0,
        OVER    = 1'b1
    } game_state_e;

endpackage

`default_nettype wire

/* rtl/score_display_top.sv */
`timescale 1ns/100ps
`default_nettype none

module score_display_top #(
    parameter int MAX_SCORE = 140
) (
    input  logic       clk,
    input  logic       nRst,
    input  logic       good_coll,
    input  logic       bad_coll,
    output logic [7:0] current_score,
    output logic [7:0] disp_score,
    output logic [3:0] bcd_ones,
    output logic [3:0] bcd_tens,
    output logic [3:0] bcd_hundreds,
    output logic [6:0] seg_ones,
    output logic [6:0] seg_tens,
    output logic [6:0] seg_hundreds,
    output logic       game_over,
    output logic       high_led
);

    game_pkg::event_e ev;
    logic             show_high;

    digit_if u_digits ();

    collision_detect u_collision_detect (
        .clk       (clk),
        .nRst      (nRst),
        .good_coll (good_coll),
        .bad_coll  (bad_coll),
        .ev        (ev)
    );

    score_tracker #(
        .MAX_SCORE (MAX_SCORE)
    ) u_score_tracker (
        .clk           (clk),
        .nRst          (nRst),
        .ev            (ev),
        .current_score (current_score),
        .disp_score    (disp_score),
        .show_high     (show_high),
        .game_over     (game_over)
    );

    bcd_converter u_bcd_converter (
        .clk        (clk),
        .nRst       (nRst),
        .disp_score (disp_score),
        .show_high  (show_high),
        .digits     (u_digits.source)
    );

    seg_encoder u_seg_encoder (
        .clk          (clk),
        .nRst         (nRst),
        .digits       (u_digits.sink),
        .seg_ones     (seg_ones),
        .seg_tens     (seg_tens),
        .seg_hundreds (seg_hundreds),
        .high_led     (high_led)
    );

    assign bcd_ones     = u_digits.ones;
    assign bcd_tens     = u_digits.tens;
    assign bcd_hundreds = u_digits.hundreds;

endmodule

`default_nettype wire

/* rtl/score_tracker.sv */
`timescale 1ns/100ps
`default_nettype none

module score_tracker #(
    parameter int MAX_SCORE = 140
) (
    input  logic             clk,
    input  logic             nRst,
    input  game_pkg::event_e ev,
    output game_pkg::score_t current_score,
    output game_pkg::score_t disp_score,
    output logic             show_high,
    output logic             game_over
);

    localparam game_pkg::score_t MAX_VAL = game_pkg::score_t'(MAX_SCORE);

    game_pkg::game_state_e state;
    game_pkg::game_state_e state_next;
    game_pkg::score_t      cur_score;
    game_pkg::score_t      cur_next;
    game_pkg::score_t      high_score;
    game_pkg::score_t      high_next;
    game_pkg::score_t      final_score;
    logic                  end_game;

    always_comb begin
        state_next  = state;
        cur_next    = cur_score;
        high_next   = high_score;
        final_score = cur_score;
        end_game    = 1'b0;

        case (ev)
            game_pkg::EV_GOOD: begin
                if (state == game_pkg::OVER) begin
                    final_score = game_pkg::score_t'(1); // first point of a new game.
                end else begin
                    final_score = cur_score + game_pkg::score_t'(1);
                end
                state_next = game_pkg::PLAYING;
                cur_next   = final_score;
                end_game   = (final_score == MAX_VAL);
            end
            game_pkg::EV_BAD: begin
                end_game = (state == game_pkg::PLAYING);
            end
            default: begin
                end_game = 1'b0;
            end
        endcase

        if (end_game) begin
            state_next = game_pkg::OVER;
            cur_next   = '0;
            if (final_score > high_score) begin
                high_next = final_score;
            end
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state      <= game_pkg::PLAYING;
            cur_score  <= '0;
            high_score <= '0;
        end else begin
            state      <= state_next;
            cur_score  <= cur_next;
            high_score <= high_next;
        end
    end

    assign game_over     = (state == game_pkg::OVER);
    assign show_high     = game_over;
    assign current_score = cur_score;
    assign disp_score    = game_over ? high_score : cur_score; // show the best while over.

endmodule

`default_nettype wire

/* rtl/seg_encoder.sv */
`timescale 1ns/100ps
`default_nettype none

module seg_encoder (
    input  logic              clk,
    input  logic              nRst,
    digit_if.sink             digits,
    output display_pkg::seg_t seg_ones,
    output display_pkg::seg_t seg_tens,
    output display_pkg::seg_t seg_hundreds,
    output logic              high_led
);

    function automatic display_pkg::seg_t seg_of(input display_pkg::bcd_t d);
        case (d)
            4'd0:    return 7'b100_0000;
            4'd1:    return 7'b111_1001;
            4'd2:    return 7'b010_0100;
            4'd3:    return 7'b011_0000;
            4'd4:    return 7'b001_1001;
            4'd5:    return 7'b001_0010;
            4'd6:    return 7'b000_0010;
            4'd7:    return 7'b111_1000;
            4'd8:    return 7'b000_0000;
            4'd9:    return 7'b001_0000;
            default: return display_pkg::SEG_BLANK; // not a decimal digit.
        endcase
    endfunction

    logic blank_hundreds;
    logic blank_tens;

    assign blank_hundreds = (digits.hundreds == 4'd0);
    assign blank_tens     = blank_hundreds && (digits.tens == 4'd0);

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            seg_ones     <= seg_of(4'd0);
            seg_tens     <= display_pkg::SEG_BLANK;
            seg_hundreds <= display_pkg::SEG_BLANK;
            high_led     <= 1'b0;
        end else begin
            seg_ones     <= seg_of(digits.ones); // the ones digit always shows.
            seg_tens     <= blank_tens ? display_pkg::SEG_BLANK : seg_of(digits.tens);
            seg_hundreds <= blank_hundreds ? display_pkg::SEG_BLANK : seg_of(digits.hundreds);
            high_led     <= digits.show_high;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line in the log.

cd "$(dirname "$0")" || exit 1

TOP=tb_score_display
BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --timescale 1ns/100ps \
    -f verilog.f \
    --top-module "$TOP" \
    --Mdir "$BUILD_DIR" \
    -o "V$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG_FILE"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see $LOG_FILE"
exit 1

/* verilog.f */
rtl/game_pkg.sv
rtl/display_pkg.sv
rtl/digit_if.sv
rtl/collision_detect.sv
rtl/score_tracker.sv
rtl/bcd_converter.sv
rtl/seg_encoder.sv
rtl/score_display_top.sv
dv/tb_score_display.sv
